// File: source/rvDecodePkg.sv
// RV32I base set only; fields an instruction does not use decode to the zero enumerator of their type
package rvDecodePkg;

    localparam int WordBits   = 32;
    localparam int ByteEnBits = WordBits / 8;
    localparam int OpcodeBits = 7;
    localparam int Funct3Bits = 3;
    localparam int Funct7Bits = 7;

    // Major opcodes
    localparam logic [OpcodeBits-1:0] OpcodeOp     = 7'b0110011;
    localparam logic [OpcodeBits-1:0] OpcodeOpImm  = 7'b0010011;
    localparam logic [OpcodeBits-1:0] OpcodeLoad   = 7'b0000011;
    localparam logic [OpcodeBits-1:0] OpcodeStore  = 7'b0100011;
    localparam logic [OpcodeBits-1:0] OpcodeLui    = 7'b0110111;
    localparam logic [OpcodeBits-1:0] OpcodeAuipc  = 7'b0010111;
    localparam logic [OpcodeBits-1:0] OpcodeJal    = 7'b1101111;
    localparam logic [OpcodeBits-1:0] OpcodeJalr   = 7'b1100111;
    localparam logic [OpcodeBits-1:0] OpcodeBranch = 7'b1100011;

    // Alt sets bit 30, selects SUB and SRA
    localparam logic [Funct7Bits-1:0] Funct7Base = 7'b0000000;
    localparam logic [Funct7Bits-1:0] Funct7Alt  = 7'b0100000;

    // Compute funct3, shared by OP and OP-IMM
    localparam logic [Funct3Bits-1:0] Funct3AddSub = 3'b000;
    localparam logic [Funct3Bits-1:0] Funct3Sll    = 3'b001;
    localparam logic [Funct3Bits-1:0] Funct3Slt    = 3'b010;
    localparam logic [Funct3Bits-1:0] Funct3Sltu   = 3'b011;
    localparam logic [Funct3Bits-1:0] Funct3Xor    = 3'b100;
    localparam logic [Funct3Bits-1:0] Funct3Srl    = 3'b101;
    localparam logic [Funct3Bits-1:0] Funct3Or     = 3'b110;
    localparam logic [Funct3Bits-1:0] Funct3And    = 3'b111;

    // Memory access widths
    localparam logic [Funct3Bits-1:0] Funct3Lb  = 3'b000;
    localparam logic [Funct3Bits-1:0] Funct3Lh  = 3'b001;
    localparam logic [Funct3Bits-1:0] Funct3Lw  = 3'b010;
    localparam logic [Funct3Bits-1:0] Funct3Lbu = 3'b100;
    localparam logic [Funct3Bits-1:0] Funct3Lhu = 3'b101;
    localparam logic [Funct3Bits-1:0] Funct3Sb  = 3'b000;
    localparam logic [Funct3Bits-1:0] Funct3Sh  = 3'b001;
    localparam logic [Funct3Bits-1:0] Funct3Sw  = 3'b010;

    // Branch conditions
    localparam logic [Funct3Bits-1:0] Funct3Beq  = 3'b000;
    localparam logic [Funct3Bits-1:0] Funct3Bne  = 3'b001;
    localparam logic [Funct3Bits-1:0] Funct3Blt  = 3'b100;
    localparam logic [Funct3Bits-1:0] Funct3Bge  = 3'b101;
    localparam logic [Funct3Bits-1:0] Funct3Bltu = 3'b110;
    localparam logic [Funct3Bits-1:0] Funct3Bgeu = 3'b111;
    localparam logic [Funct3Bits-1:0] Funct3Jalr = 3'b000;

    // Store lane masks
    localparam logic [ByteEnBits-1:0] ByteEnByte = 4'b0001;
    localparam logic [ByteEnBits-1:0] ByteEnHalf = 4'b0011;
    localparam logic [ByteEnBits-1:0] ByteEnWord = 4'b1111;

    typedef logic [WordBits-1:0] word_t;

    typedef enum logic [1:0] {PcPlus4, JumpReg, JumpPc, BranchCond} pcSrc_t;
    typedef enum logic [2:0] {NoBranch, Beq, Bne, Blt, Bge, Bltu, Bgeu} condBranch_t;
    typedef enum logic [2:0] {ImmNone, IType, Shamt, SType, BType, UType, JType} immSrc_t;
    // Link value for jumps is MiscPcPlus4
    typedef enum logic [1:0] {MiscNone, WriteData, PcPlusImm, MiscPcPlus4} miscSrc_t;
    typedef enum logic [0:0] {Rs2, Imm} aluSrcB_t;
    typedef enum logic [3:0] {Add, Sub, Or, And, Xor, Sll, Slt, Sltu, Srl, Sra} aluOp_t;
    typedef enum logic [1:0] {Alu, AluOpB, UpdatedPc} computeSrc_t;
    typedef enum logic [0:0] {Compute, Memory} resultSrc_t;
    typedef enum logic [2:0] {
        NoTrunc, Byte, HalfWord, Word, ByteUnsigned, HalfWordUnsigned
    } truncSrc_t;

    typedef struct packed {
        logic                  regWrite;
        logic                  memEn;
        logic                  memWrite;
        logic [ByteEnBits-1:0] byteEn;
        pcSrc_t                pcSrc;
        condBranch_t           condBranch;
        immSrc_t               immSrc;
        miscSrc_t              miscSrc;
        aluSrcB_t              aluSrcB;
        aluOp_t                aluOp;
        computeSrc_t           computeSrc;
        resultSrc_t            resultSrc;
        truncSrc_t             truncSrc;
    } ctrlWord_t;

    // Every enum at its first value, all enables low
    localparam ctrlWord_t CtrlDefault = '0;

    function automatic logic [OpcodeBits-1:0] opcodeOf(input word_t instr);
        return instr[OpcodeBits-1:0];
    endfunction

    function automatic logic [Funct3Bits-1:0] funct3Of(input word_t instr);
        return instr[14:12];
    endfunction

    function automatic logic [Funct7Bits-1:0] funct7Of(input word_t instr);
        return instr[31:25];
    endfunction

endpackage

// File: source/aluDecoder.sv
`timescale 1ns/1ps
// Combinational; only OP, OP-IMM, LUI and AUIPC hit, any other encoding gives aluHit low and the default word
module aluDecoder (
    input  rvDecodePkg::word_t     instr,
    output rvDecodePkg::ctrlWord_t aluCtrl,
    output logic                   aluHit
);
    import rvDecodePkg::*;

    logic [OpcodeBits-1:0] opcode;
    logic [Funct3Bits-1:0] funct3;
    logic [Funct7Bits-1:0] funct7;

    assign opcode = opcodeOf(instr);
    assign funct3 = funct3Of(instr);
    assign funct7 = funct7Of(instr);

    always_comb begin
        aluCtrl = CtrlDefault;
        aluHit  = 1'b1;
        case (opcode)
            OpcodeOp: begin
                aluCtrl.regWrite = 1'b1;
                aluCtrl.aluSrcB  = Rs2;
                case ({funct7, funct3})
                    {Funct7Base, Funct3AddSub}: aluCtrl.aluOp = Add;
                    {Funct7Alt,  Funct3AddSub}: aluCtrl.aluOp = Sub;
                    {Funct7Base, Funct3Or}:     aluCtrl.aluOp = Or;
                    {Funct7Base, Funct3And}:    aluCtrl.aluOp = And;
                    {Funct7Base, Funct3Xor}:    aluCtrl.aluOp = Xor;
                    {Funct7Base, Funct3Sll}:    aluCtrl.aluOp = Sll;
                    {Funct7Base, Funct3Slt}:    aluCtrl.aluOp = Slt;
                    {Funct7Base, Funct3Sltu}:   aluCtrl.aluOp = Sltu;
                    {Funct7Base, Funct3Srl}:    aluCtrl.aluOp = Srl;
                    {Funct7Alt,  Funct3Srl}:    aluCtrl.aluOp = Sra;
                    default:                    aluHit = 1'b0;
                endcase
            end
            OpcodeOpImm: begin
                aluCtrl.regWrite = 1'b1;
                aluCtrl.aluSrcB  = Imm;
                aluCtrl.immSrc   = IType;
                case (funct3)
                    Funct3AddSub: aluCtrl.aluOp = Add;
                    Funct3Or:     aluCtrl.aluOp = Or;
                    Funct3And:    aluCtrl.aluOp = And;
                    Funct3Xor:    aluCtrl.aluOp = Xor;
                    Funct3Slt:    aluCtrl.aluOp = Slt;
                    Funct3Sltu:   aluCtrl.aluOp = Sltu;
                    Funct3Sll: begin
                        aluCtrl.immSrc = Shamt;
                        aluCtrl.aluOp  = Sll;
                        aluHit         = (funct7 == Funct7Base);
                    end
                    Funct3Srl: begin
                        // Shamt sits in rs2 field, funct7 only picks the shift kind
                        aluCtrl.immSrc = Shamt;
                        aluCtrl.aluOp  = (funct7 == Funct7Alt) ? Sra : Srl;
                        aluHit         = (funct7 == Funct7Base) || (funct7 == Funct7Alt);
                    end
                    default:      aluHit = 1'b0;
                endcase
            end
            OpcodeLui: begin
                aluCtrl.regWrite   = 1'b1;
                aluCtrl.immSrc     = UType;
                aluCtrl.aluSrcB    = Imm;
                aluCtrl.computeSrc = AluOpB;
            end
            OpcodeAuipc: begin
                aluCtrl.regWrite   = 1'b1;
                aluCtrl.immSrc     = UType;
                aluCtrl.miscSrc    = PcPlusImm;
                aluCtrl.computeSrc = UpdatedPc;
            end
            default: aluHit = 1'b0;
        endcase

        if (!aluHit) begin
            aluCtrl = CtrlDefault;
        end
    end

    // Every compute class writes rd
    always_comb begin
        assert final (!aluHit || aluCtrl.regWrite)
            else $error("aluDecoder: hit without regWrite");
    end

endmodule

// File: source/memFlowDecoder.sv
`timescale 1ns/1ps
// Combinational; only LOAD, STORE, JAL, JALR and BRANCH hit, JALR needs funct3 zero
module memFlowDecoder (
    input  rvDecodePkg::word_t     instr,
    output rvDecodePkg::ctrlWord_t memCtrl,
    output logic                   memHit
);
    import rvDecodePkg::*;

    logic [OpcodeBits-1:0] opcode;
    logic [Funct3Bits-1:0] funct3;

    assign opcode = opcodeOf(instr);
    assign funct3 = funct3Of(instr);

    always_comb begin
        memCtrl = CtrlDefault;
        memHit  = 1'b1;
        case (opcode)
            OpcodeLoad: begin
                memCtrl.regWrite  = 1'b1;
                memCtrl.memEn     = 1'b1;
                memCtrl.immSrc    = IType;
                memCtrl.aluSrcB   = Imm;
                memCtrl.resultSrc = Memory;
                case (funct3)
                    Funct3Lb:  memCtrl.truncSrc = Byte;
                    Funct3Lh:  memCtrl.truncSrc = HalfWord;
                    Funct3Lw:  memCtrl.truncSrc = Word;
                    Funct3Lbu: memCtrl.truncSrc = ByteUnsigned;
                    Funct3Lhu: memCtrl.truncSrc = HalfWordUnsigned;
                    default:   memHit = 1'b0;
                endcase
            end
            OpcodeStore: begin
                memCtrl.memEn    = 1'b1;
                memCtrl.memWrite = 1'b1;
                memCtrl.immSrc   = SType;
                memCtrl.aluSrcB  = Imm;
                memCtrl.miscSrc  = WriteData;
                case (funct3)
                    Funct3Sb: memCtrl.byteEn = ByteEnByte;
                    Funct3Sh: memCtrl.byteEn = ByteEnHalf;
                    Funct3Sw: memCtrl.byteEn = ByteEnWord;
                    default:  memHit = 1'b0;
                endcase
            end
            // Both jumps link PC+4 into rd
            OpcodeJal: begin
                memCtrl.regWrite   = 1'b1;
                memCtrl.pcSrc      = JumpPc;
                memCtrl.immSrc     = JType;
                memCtrl.miscSrc    = MiscPcPlus4;
                memCtrl.computeSrc = UpdatedPc;
            end
            OpcodeJalr: begin
                memCtrl.regWrite   = 1'b1;
                memCtrl.pcSrc      = JumpReg;
                memCtrl.immSrc     = IType;
                memCtrl.aluSrcB    = Imm;
                memCtrl.miscSrc    = MiscPcPlus4;
                memCtrl.computeSrc = UpdatedPc;
                memHit             = (funct3 == Funct3Jalr);
            end
            OpcodeBranch: begin
                // Compare done by subtraction in the ALU
                memCtrl.pcSrc   = BranchCond;
                memCtrl.immSrc  = BType;
                memCtrl.aluOp   = Sub;
                memCtrl.miscSrc = PcPlusImm;
                case (funct3)
                    Funct3Beq:  memCtrl.condBranch = Beq;
                    Funct3Bne:  memCtrl.condBranch = Bne;
                    Funct3Blt:  memCtrl.condBranch = Blt;
                    Funct3Bge:  memCtrl.condBranch = Bge;
                    Funct3Bltu: memCtrl.condBranch = Bltu;
                    Funct3Bgeu: memCtrl.condBranch = Bgeu;
                    default:    memHit = 1'b0;
                endcase
            end
            default: memHit = 1'b0;
        endcase

        if (!memHit) begin
            memCtrl = CtrlDefault;
        end
    end

    // A store must touch at least one lane
    always_comb begin
        assert final (!memCtrl.memWrite || (memCtrl.byteEn != '0))
            else $error("memFlowDecoder: store with empty byte enables");
    end

endmodule

// File: source/decodeSelect.sv
`timescale 1ns/1ps
// One cycle latency, no back-pressure; idle cycles register the default word with illegal low
module decodeSelect (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   instrValid,
    input  rvDecodePkg::ctrlWord_t aluCtrl,
    input  rvDecodePkg::ctrlWord_t memCtrl,
    input  logic                   aluHit,
    input  logic                   memHit,
    output logic                   ctrlValid,
    output rvDecodePkg::ctrlWord_t ctrl,
    output logic                   illegal
);
    import rvDecodePkg::*;

    ctrlWord_t merged;
    logic      noHit;

    assign noHit = !(aluHit || memHit);

    always_comb begin
        if (aluHit) begin
            merged = aluCtrl;
        end else if (memHit) begin
            merged = memCtrl;
        end else begin
            merged = CtrlDefault;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrlValid <= 1'b0;
            ctrl      <= CtrlDefault;
            illegal   <= 1'b0;
        end else begin
            ctrlValid <= instrValid;
            ctrl      <= instrValid ? merged : CtrlDefault;
            illegal   <= instrValid && noHit;
        end
    end

    // Decoders own disjoint opcode sets
    oneHit: assert property (@(posedge clk) disable iff (!arstN)
        !(aluHit && memHit))
        else $error("decodeSelect: both decoders hit");

    illegalQuiet: assert property (@(posedge clk) disable iff (!arstN)
        illegal |-> (!ctrl.regWrite && !ctrl.memEn))
        else $error("decodeSelect: illegal word has enables set");

    // Valid strobe delayed by exactly one edge
    validDelay: assert property (@(posedge clk) disable iff (!arstN)
        ##1 (ctrlValid == $past(instrValid)))
        else $error("decodeSelect: ctrlValid out of step with instrValid");

endmodule

// File: source/rvDecoder.sv
`timescale 1ns/1ps
// RV32I decode stage, one instruction per cycle, result one cycle later, no stall input
module rvDecoder (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   instrValid,
    input  rvDecodePkg::word_t     instr,
    output logic                   ctrlValid,
    output rvDecodePkg::ctrlWord_t ctrl,
    output logic                   illegal
);
    import rvDecodePkg::*;

    ctrlWord_t aluCtrl;
    ctrlWord_t memCtrl;
    logic      aluHit;
    logic      memHit;

    aluDecoder aluDec (
        .instr   (instr),
        .aluCtrl (aluCtrl),
        .aluHit  (aluHit)
    );

    memFlowDecoder memDec (
        .instr   (instr),
        .memCtrl (memCtrl),
        .memHit  (memHit)
    );

    decodeSelect select (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .aluCtrl    (aluCtrl),
        .memCtrl    (memCtrl),
        .aluHit     (aluHit),
        .memHit     (memHit),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl),
        .illegal    (illegal)
    );

endmodule

// File: verif/rvDecoderTb.sv
// Directed and seeded random checks of the decoder; expected words come from the RV32I rules below
`timescale 1ns/1ps
module rvDecoderTb;
    import rvDecodePkg::*;

    localparam int ClkPeriod   = 100;
    localparam int NumDirected = 50;
    localparam int NumRandom   = 200;
    // Two cycles per instruction plus reset and slack
    localparam int WatchdogCycles = 2 * (NumDirected + NumRandom) + 3 + 20;

    logic      clk = 1'b0;
    logic      arstN;
    logic      instrValid;
    word_t     instr;
    logic      ctrlValid;
    ctrlWord_t ctrl;
    logic      illegal;
    int        errors = 0;
    int        checks = 0;
    integer    seed = 30739;

    rvDecoder UUT (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl),
        .illegal    (illegal)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // Register fields fixed at rs2=5, rs1=6, rd=7
    function automatic word_t encode(input logic [6:0] f7, input logic [2:0] f3,
                                     input logic [6:0] op);
        return {f7, 5'd5, 5'd6, f3, 5'd7, op};
    endfunction

    function automatic ctrlWord_t expectWord(input word_t w, output logic legal);
        ctrlWord_t e;
        logic [6:0] op;
        logic [2:0] f3;
        logic [6:0] f7;
        e = '0;
        legal = 1'b1;
        op = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        case (op)
            7'b0110011: begin
                e.regWrite = 1'b1;
                case ({f7, f3})
                    {7'h00, 3'd0}: e.aluOp = Add;
                    {7'h20, 3'd0}: e.aluOp = Sub;
                    {7'h00, 3'd1}: e.aluOp = Sll;
                    {7'h00, 3'd2}: e.aluOp = Slt;
                    {7'h00, 3'd3}: e.aluOp = Sltu;
                    {7'h00, 3'd4}: e.aluOp = Xor;
                    {7'h00, 3'd5}: e.aluOp = Srl;
                    {7'h20, 3'd5}: e.aluOp = Sra;
                    {7'h00, 3'd6}: e.aluOp = Or;
                    {7'h00, 3'd7}: e.aluOp = And;
                    default:       legal = 1'b0;
                endcase
            end
            7'b0010011: begin
                e.regWrite = 1'b1;
                e.aluSrcB  = Imm;
                e.immSrc   = IType;
                case (f3)
                    3'd0: e.aluOp = Add;
                    3'd2: e.aluOp = Slt;
                    3'd3: e.aluOp = Sltu;
                    3'd4: e.aluOp = Xor;
                    3'd6: e.aluOp = Or;
                    3'd7: e.aluOp = And;
                    3'd1: begin
                        e.immSrc = Shamt;
                        e.aluOp  = Sll;
                        legal    = (f7 == 7'h00);
                    end
                    default: begin
                        e.immSrc = Shamt;
                        e.aluOp  = (f7 == 7'h20) ? Sra : Srl;
                        legal    = (f7 == 7'h00) || (f7 == 7'h20);
                    end
                endcase
            end
            7'b0000011: begin
                e.regWrite  = 1'b1;
                e.memEn     = 1'b1;
                e.immSrc    = IType;
                e.aluSrcB   = Imm;
                e.resultSrc = Memory;
                case (f3)
                    3'd0:    e.truncSrc = Byte;
                    3'd1:    e.truncSrc = HalfWord;
                    3'd2:    e.truncSrc = Word;
                    3'd4:    e.truncSrc = ByteUnsigned;
                    3'd5:    e.truncSrc = HalfWordUnsigned;
                    default: legal = 1'b0;
                endcase
            end
            7'b0100011: begin
                e.memEn    = 1'b1;
                e.memWrite = 1'b1;
                e.immSrc   = SType;
                e.aluSrcB  = Imm;
                e.miscSrc  = WriteData;
                case (f3)
                    3'd0:    e.byteEn = 4'b0001;
                    3'd1:    e.byteEn = 4'b0011;
                    3'd2:    e.byteEn = 4'b1111;
                    default: legal = 1'b0;
                endcase
            end
            7'b0110111: begin
                e.regWrite   = 1'b1;
                e.immSrc     = UType;
                e.aluSrcB    = Imm;
                e.computeSrc = AluOpB;
            end
            7'b0010111: begin
                e.regWrite   = 1'b1;
                e.immSrc     = UType;
                e.miscSrc    = PcPlusImm;
                e.computeSrc = UpdatedPc;
            end
            7'b1101111: begin
                e.regWrite   = 1'b1;
                e.pcSrc      = JumpPc;
                e.immSrc     = JType;
                e.miscSrc    = MiscPcPlus4;
                e.computeSrc = UpdatedPc;
            end
            7'b1100111: begin
                e.regWrite   = 1'b1;
                e.pcSrc      = JumpReg;
                e.immSrc     = IType;
                e.aluSrcB    = Imm;
                e.miscSrc    = MiscPcPlus4;
                e.computeSrc = UpdatedPc;
                legal        = (f3 == 3'd0);
            end
            7'b1100011: begin
                e.pcSrc   = BranchCond;
                e.immSrc  = BType;
                e.aluOp   = Sub;
                e.miscSrc = PcPlusImm;
                case (f3)
                    3'd0:    e.condBranch = Beq;
                    3'd1:    e.condBranch = Bne;
                    3'd4:    e.condBranch = Blt;
                    3'd5:    e.condBranch = Bge;
                    3'd6:    e.condBranch = Bltu;
                    3'd7:    e.condBranch = Bgeu;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        // Illegal words carry no enables and every field at its default
        if (!legal) begin
            e = '0;
        end
        return e;
    endfunction

    task automatic compareValue(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // One instruction, then idle; result read at the falling edge after the capture edge
    task automatic decodeOne(input string name, input word_t word, input logic wantIllegal);
        ctrlWord_t expWord;
        logic      legal;
        expWord = expectWord(word, legal);
        @(posedge clk);
        instr      <= word;
        instrValid <= 1'b1;
        @(posedge clk);
        instrValid <= 1'b0;
        @(negedge clk);
        compareValue({name, " ctrlValid"}, 1'b1, ctrlValid);
        compareValue({name, " illegal"}, wantIllegal, illegal);
        compareValue({name, " ctrl"}, expWord, ctrl);
    endtask

    task automatic testRType();
        decodeOne("add", encode(7'h00, 3'd0, 7'b0110011), 1'b0);
        decodeOne("sub", encode(7'h20, 3'd0, 7'b0110011), 1'b0);
        decodeOne("sll", encode(7'h00, 3'd1, 7'b0110011), 1'b0);
        decodeOne("slt", encode(7'h00, 3'd2, 7'b0110011), 1'b0);
        decodeOne("sltu", encode(7'h00, 3'd3, 7'b0110011), 1'b0);
        decodeOne("xor", encode(7'h00, 3'd4, 7'b0110011), 1'b0);
        decodeOne("srl", encode(7'h00, 3'd5, 7'b0110011), 1'b0);
        decodeOne("sra", encode(7'h20, 3'd5, 7'b0110011), 1'b0);
        decodeOne("or", encode(7'h00, 3'd6, 7'b0110011), 1'b0);
        decodeOne("and", encode(7'h00, 3'd7, 7'b0110011), 1'b0);
        decodeOne("r bad funct7", encode(7'h01, 3'd0, 7'b0110011), 1'b1);
        decodeOne("r alt or", encode(7'h20, 3'd6, 7'b0110011), 1'b1);
    endtask

    // Immediate bits in funct7 position must not matter outside shifts
    task automatic testIType();
        decodeOne("addi", encode(7'h55, 3'd0, 7'b0010011), 1'b0);
        decodeOne("slti", encode(7'h7f, 3'd2, 7'b0010011), 1'b0);
        decodeOne("sltiu", encode(7'h01, 3'd3, 7'b0010011), 1'b0);
        decodeOne("xori", encode(7'h20, 3'd4, 7'b0010011), 1'b0);
        decodeOne("ori", encode(7'h40, 3'd6, 7'b0010011), 1'b0);
        decodeOne("andi", encode(7'h00, 3'd7, 7'b0010011), 1'b0);
        decodeOne("slli", encode(7'h00, 3'd1, 7'b0010011), 1'b0);
        decodeOne("srli", encode(7'h00, 3'd5, 7'b0010011), 1'b0);
        decodeOne("srai", encode(7'h20, 3'd5, 7'b0010011), 1'b0);
        decodeOne("slli alt", encode(7'h20, 3'd1, 7'b0010011), 1'b1);
        decodeOne("srli bad funct7", encode(7'h01, 3'd5, 7'b0010011), 1'b1);
    endtask

    task automatic testMemory();
        decodeOne("lb", encode(7'h12, 3'd0, 7'b0000011), 1'b0);
        decodeOne("lh", encode(7'h12, 3'd1, 7'b0000011), 1'b0);
        decodeOne("lw", encode(7'h12, 3'd2, 7'b0000011), 1'b0);
        decodeOne("lbu", encode(7'h12, 3'd4, 7'b0000011), 1'b0);
        decodeOne("lhu", encode(7'h12, 3'd5, 7'b0000011), 1'b0);
        decodeOne("load funct3 3", encode(7'h12, 3'd3, 7'b0000011), 1'b1);
        decodeOne("sb", encode(7'h34, 3'd0, 7'b0100011), 1'b0);
        decodeOne("sh", encode(7'h34, 3'd1, 7'b0100011), 1'b0);
        decodeOne("sw", encode(7'h34, 3'd2, 7'b0100011), 1'b0);
        decodeOne("store funct3 3", encode(7'h34, 3'd3, 7'b0100011), 1'b1);
    endtask

    task automatic testFlow();
        decodeOne("beq", encode(7'h00, 3'd0, 7'b1100011), 1'b0);
        decodeOne("bne", encode(7'h00, 3'd1, 7'b1100011), 1'b0);
        decodeOne("blt", encode(7'h00, 3'd4, 7'b1100011), 1'b0);
        decodeOne("bge", encode(7'h00, 3'd5, 7'b1100011), 1'b0);
        decodeOne("bltu", encode(7'h00, 3'd6, 7'b1100011), 1'b0);
        decodeOne("bgeu", encode(7'h00, 3'd7, 7'b1100011), 1'b0);
        decodeOne("branch funct3 2", encode(7'h00, 3'd2, 7'b1100011), 1'b1);
        decodeOne("jal", encode(7'h3a, 3'd5, 7'b1101111), 1'b0);
        decodeOne("jalr", encode(7'h3a, 3'd0, 7'b1100111), 1'b0);
        decodeOne("jalr funct3 1", encode(7'h3a, 3'd1, 7'b1100111), 1'b1);
        decodeOne("lui", encode(7'h6b, 3'd3, 7'b0110111), 1'b0);
        decodeOne("auipc", encode(7'h6b, 3'd3, 7'b0010111), 1'b0);
    endtask

    // Half the words get a supported opcode so legal encodings are exercised too
    task automatic testRandom();
        logic [6:0] opTable [9];
        word_t      word;
        logic       legal;
        opTable = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011, 7'b0110111,
                    7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011};
        for (int i = 0; i < NumRandom; i++) begin
            word = $random(seed);
            if (i % 2 == 0) begin
                word[6:0] = opTable[{$random(seed)} % 9];
            end
            void'(expectWord(word, legal));
            decodeOne($sformatf("random %0d", i), word, !legal);
        end
    endtask

    task automatic testValidTiming();
        word_t     first;
        word_t     second;
        ctrlWord_t expFirst;
        ctrlWord_t expSecond;
        logic      legalFirst;
        logic      legalSecond;
        first     = encode(7'h20, 3'd0, 7'b0110011);
        second    = encode(7'h00, 3'd3, 7'b0100011);
        expFirst  = expectWord(first, legalFirst);
        expSecond = expectWord(second, legalSecond);
        @(negedge clk);
        compareValue("reset ctrlValid", 1'b0, ctrlValid);
        compareValue("reset illegal", 1'b0, illegal);
        compareValue("reset ctrl", CtrlDefault, ctrl);
        @(posedge clk);
        instr      <= first;
        instrValid <= 1'b1;
        @(posedge clk);
        instr <= second;
        @(negedge clk);
        compareValue("b2b first ctrlValid", 1'b1, ctrlValid);
        compareValue("b2b first ctrl", expFirst, ctrl);
        compareValue("b2b first illegal", !legalFirst, illegal);
        @(posedge clk);
        instrValid <= 1'b0;
        @(negedge clk);
        compareValue("b2b second ctrlValid", 1'b1, ctrlValid);
        compareValue("b2b second ctrl", expSecond, ctrl);
        compareValue("b2b second illegal", !legalSecond, illegal);
        @(negedge clk);
        compareValue("idle ctrlValid", 1'b0, ctrlValid);
    endtask

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles, tests did not finish", WatchdogCycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        testValidTiming();
        testRType();
        testIType();
        testMemory();
        testFlow();
        testRandom();
        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rvDecoder.f
source/rvDecodePkg.sv
source/aluDecoder.sv
source/memFlowDecoder.sv
source/decodeSelect.sv
source/rvDecoder.sv
verif/rvDecoderTb.sv

// File: Bender.yml
package:
  name: rvDecoder

sources:
  # Package first, then the decoders, the selector and the top level
  - files:
      - source/rvDecodePkg.sv
      - source/aluDecoder.sv
      - source/memFlowDecoder.sv
      - source/decodeSelect.sv
      - source/rvDecoder.sv

  - target: test
    files:
      - verif/rvDecoderTb.sv
